//--- source/exec_defs.svh
`ifndef EXEC_DEFS_SVH
`define EXEC_DEFS_SVH

// data path width
`define EXEC_XLEN 32

// physical register id width
`define EXEC_RNID_W 6

// number of physical GPRs
`define EXEC_PHYS_REGS (1 << `EXEC_RNID_W)

// slot 0 is this pipe, slot 1 is an external writer
`define EXEC_TGT_BUS_SIZE 2

// reservation station entries, index is one-hot
`define EXEC_RV_ENTRIES 8

`endif

//--- source/exec_pkg.sv
`include "exec_defs.svh"

package exec_pkg;

  typedef enum logic {
    GPR = 1'b0,
    FPR = 1'b1
  } reg_type_e;

  // instruction word views
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_view_t;

  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_view_t;

  typedef struct packed {
    logic [19:0] imm20;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_view_t;

  typedef union packed {
    r_view_t r_view;
    i_view_t i_view;
    u_view_t u_view;
  } inst_u;

  typedef struct packed {
    logic                        valid;
    inst_u                       inst;
    logic                        rs1_valid;
    reg_type_e                   rs1_type;
    logic [`EXEC_RNID_W-1:0]     rs1_rnid;
    logic                        rs2_valid;
    reg_type_e                   rs2_type;
    logic [`EXEC_RNID_W-1:0]     rs2_rnid;
    logic                        rd_valid;
    reg_type_e                   rd_type;
    logic [`EXEC_RNID_W-1:0]     rd_rnid;
    logic [`EXEC_RV_ENTRIES-1:0] index;
  } issue_t;

  typedef enum logic [2:0] {
    OP_LUI,
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR
  } alu_op_e;

  typedef struct packed {
    alu_op_e op;
    logic    imm;
    logic    legal;
  } pipe_ctrl_t;

  typedef struct packed {
    logic                    valid;
    logic [`EXEC_RNID_W-1:0] rnid;
  } regread_t;

  typedef struct packed {
    logic                    valid;
    reg_type_e               rd_type;
    logic [`EXEC_RNID_W-1:0] rd_rnid;
  } release_t;

  typedef struct packed {
    logic                    valid;
    reg_type_e               rd_type;
    logic [`EXEC_RNID_W-1:0] rd_rnid;
    logic [`EXEC_XLEN-1:0]   rd_data;
  } target_t;

endpackage

//--- source/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder (
  input  exec_pkg::inst_u      i_inst,
  output exec_pkg::pipe_ctrl_t o_ctrl
);

  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

  always_comb begin
    o_ctrl.op    = exec_pkg::OP_ADD;
    o_ctrl.imm   = 1'b0;
    o_ctrl.legal = 1'b0;

    case (i_inst.r_view.opcode)
      OPC_LUI: begin
        o_ctrl.op    = exec_pkg::OP_LUI;
        o_ctrl.legal = 1'b1;
      end
      OPC_OP: begin
        // only funct7 0x00, plus 0x20 for sub
        o_ctrl.legal = 1'b1;
        case ({i_inst.r_view.funct7, i_inst.r_view.funct3})
          {7'b0000000, 3'b000}: o_ctrl.op = exec_pkg::OP_ADD;
          {7'b0100000, 3'b000}: o_ctrl.op = exec_pkg::OP_SUB;
          {7'b0000000, 3'b100}: o_ctrl.op = exec_pkg::OP_XOR;
          {7'b0000000, 3'b110}: o_ctrl.op = exec_pkg::OP_OR;
          {7'b0000000, 3'b111}: o_ctrl.op = exec_pkg::OP_AND;
          default:              o_ctrl.legal = 1'b0;
        endcase
      end
      OPC_OP_IMM: begin
        o_ctrl.imm   = 1'b1;
        o_ctrl.legal = 1'b1;
        case (i_inst.i_view.funct3)
          3'b000:  o_ctrl.op = exec_pkg::OP_ADD;
          3'b100:  o_ctrl.op = exec_pkg::OP_XOR;
          3'b110:  o_ctrl.op = exec_pkg::OP_OR;
          3'b111:  o_ctrl.op = exec_pkg::OP_AND;
          // shifts and compares not supported
          default: o_ctrl.legal = 1'b0;
        endcase
      end
      default: begin
        o_ctrl.legal = 1'b0;
      end
    endcase
  end

endmodule

//--- source/phys_regfile.sv
`timescale 1ns/1ps
`include "exec_defs.svh"

module phys_regfile (
  input  logic                  i_clk,
  input  logic                  i_reset_n,
  input  exec_pkg::regread_t    i_rd_req [2],
  output logic [`EXEC_XLEN-1:0] o_rd_data [2],
  input  exec_pkg::target_t     i_targets [`EXEC_TGT_BUS_SIZE]
);

  logic [`EXEC_XLEN-1:0]   r_regs [`EXEC_PHYS_REGS];
  logic [`EXEC_RNID_W-1:0] r_rd_rnid [2];

  // read ids, held while no request
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_rd_rnid[0] <= '0;
      r_rd_rnid[1] <= '0;
    end else begin
      for (int p = 0; p < 2; p++) begin
        if (i_rd_req[p].valid) begin
          r_rd_rnid[p] <= i_rd_req[p].rnid;
        end
      end
    end
  end

  // stored value, overridden by a same-cycle gpr write on the bus
  always_comb begin
    for (int p = 0; p < 2; p++) begin
      o_rd_data[p] = r_regs[r_rd_rnid[p]];
      for (int t = 0; t < `EXEC_TGT_BUS_SIZE; t++) begin
        if (i_targets[t].valid && (i_targets[t].rd_type == exec_pkg::GPR) &&
            (i_targets[t].rd_rnid == r_rd_rnid[p])) begin
          o_rd_data[p] = i_targets[t].rd_data;
        end
      end
    end
  end

  // fpr targets are ignored here
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int r = 0; r < `EXEC_PHYS_REGS; r++) begin
        r_regs[r] <= '0;
      end
    end else begin
      for (int t = 0; t < `EXEC_TGT_BUS_SIZE; t++) begin
        if (i_targets[t].valid && (i_targets[t].rd_type == exec_pkg::GPR)) begin
          r_regs[i_targets[t].rd_rnid] <= i_targets[t].rd_data;
        end
      end
    end
  end

endmodule

//--- source/alu_pipe.sv
`timescale 1ns/1ps
`include "exec_defs.svh"

module alu_pipe (
  input  logic                        i_clk,
  input  logic                        i_reset_n,
  input  exec_pkg::issue_t            i_issue,
  output exec_pkg::inst_u             o_ex0_inst,
  input  exec_pkg::pipe_ctrl_t        i_ex0_ctrl,
  output exec_pkg::regread_t          o_rd_req [2],
  input  logic [`EXEC_XLEN-1:0]       i_rd_data [2],
  input  exec_pkg::target_t           i_targets [`EXEC_TGT_BUS_SIZE],
  output exec_pkg::release_t          o_release,
  output exec_pkg::target_t           o_target,
  output logic                        o_done,
  output logic [`EXEC_RV_ENTRIES-1:0] o_done_index
);

  exec_pkg::issue_t     r_ex1_issue;
  exec_pkg::pipe_ctrl_t r_ex1_ctrl;
  logic [`EXEC_XLEN-1:0] w_ex1_rs2_data;

  exec_pkg::issue_t     r_ex2_issue;
  exec_pkg::pipe_ctrl_t r_ex2_ctrl;
  logic [`EXEC_XLEN-1:0] r_ex2_rs1_data;
  logic [`EXEC_XLEN-1:0] r_ex2_rs2_data;

  logic [`EXEC_TGT_BUS_SIZE-1:0] w_ex2_rs1_hit;
  logic [`EXEC_TGT_BUS_SIZE-1:0] w_ex2_rs2_hit;
  logic [`EXEC_XLEN-1:0]         w_ex2_rs1_fwd;
  logic [`EXEC_XLEN-1:0]         w_ex2_rs2_fwd;
  logic [`EXEC_XLEN-1:0]         w_ex2_rs1;
  logic [`EXEC_XLEN-1:0]         w_ex2_rs2;
  logic [`EXEC_XLEN-1:0]         w_ex2_result;

  exec_pkg::issue_t      r_ex3_issue;
  logic                  r_ex3_legal;
  logic [`EXEC_XLEN-1:0] r_ex3_result;

  function automatic logic src_hit(input logic                    src_valid,
                                   input exec_pkg::reg_type_e     src_type,
                                   input logic [`EXEC_RNID_W-1:0] src_rnid,
                                   input exec_pkg::target_t       tgt);
    src_hit = src_valid & tgt.valid & (src_type == tgt.rd_type) & (src_rnid == tgt.rd_rnid);
  endfunction

  // ex0: decode and register read requests
  assign o_ex0_inst = i_issue.inst;

  assign o_rd_req[0].valid = i_issue.valid & i_issue.rs1_valid;
  assign o_rd_req[0].rnid  = i_issue.rs1_rnid;
  assign o_rd_req[1].valid = i_issue.valid & i_issue.rs2_valid;
  assign o_rd_req[1].rnid  = i_issue.rs2_rnid;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex1_issue <= '0;
      r_ex1_ctrl  <= '0;
      r_ex2_issue <= '0;
      r_ex2_ctrl  <= '0;
      r_ex3_issue <= '0;
      r_ex3_legal <= 1'b0;
    end else begin
      r_ex1_issue <= i_issue;
      r_ex1_ctrl  <= i_ex0_ctrl;
      r_ex2_issue <= r_ex1_issue;
      r_ex2_ctrl  <= r_ex1_ctrl;
      r_ex3_issue <= r_ex2_issue;
      r_ex3_legal <= r_ex2_ctrl.legal;
    end
  end

  // ex1: early notice to the scheduler
  assign o_release.valid   = r_ex1_issue.valid & r_ex1_issue.rd_valid & r_ex1_ctrl.legal;
  assign o_release.rd_type = r_ex1_issue.rd_type;
  assign o_release.rd_rnid = r_ex1_issue.rd_rnid;

  // sign-extended immediate replaces rs2
  assign w_ex1_rs2_data = r_ex1_ctrl.imm ?
                          {{(`EXEC_XLEN-12){r_ex1_issue.inst.i_view.imm12[11]}},
                           r_ex1_issue.inst.i_view.imm12} :
                          i_rd_data[1];

  always_ff @(posedge i_clk) begin
    r_ex2_rs1_data <= i_rd_data[0];
    r_ex2_rs2_data <= w_ex1_rs2_data;
  end

  // ex2: one-hot or of matching bus slots
  always_comb begin
    w_ex2_rs1_fwd = '0;
    w_ex2_rs2_fwd = '0;
    for (int i = 0; i < `EXEC_TGT_BUS_SIZE; i++) begin
      w_ex2_rs1_hit[i] = src_hit(r_ex2_issue.rs1_valid, r_ex2_issue.rs1_type,
                                 r_ex2_issue.rs1_rnid, i_targets[i]);
      // never forward over an immediate
      w_ex2_rs2_hit[i] = src_hit(r_ex2_issue.rs2_valid & ~r_ex2_ctrl.imm, r_ex2_issue.rs2_type,
                                 r_ex2_issue.rs2_rnid, i_targets[i]);
      w_ex2_rs1_fwd = w_ex2_rs1_fwd | (i_targets[i].rd_data & {`EXEC_XLEN{w_ex2_rs1_hit[i]}});
      w_ex2_rs2_fwd = w_ex2_rs2_fwd | (i_targets[i].rd_data & {`EXEC_XLEN{w_ex2_rs2_hit[i]}});
    end
  end

  assign w_ex2_rs1 = (|w_ex2_rs1_hit) ? w_ex2_rs1_fwd : r_ex2_rs1_data;
  assign w_ex2_rs2 = (|w_ex2_rs2_hit) ? w_ex2_rs2_fwd : r_ex2_rs2_data;

  always_comb begin
    case (r_ex2_ctrl.op)
      exec_pkg::OP_LUI: w_ex2_result = {r_ex2_issue.inst.u_view.imm20, 12'h000};
      exec_pkg::OP_ADD: w_ex2_result = w_ex2_rs1 + w_ex2_rs2;
      exec_pkg::OP_SUB: w_ex2_result = w_ex2_rs1 - w_ex2_rs2;
      exec_pkg::OP_AND: w_ex2_result = w_ex2_rs1 & w_ex2_rs2;
      exec_pkg::OP_OR:  w_ex2_result = w_ex2_rs1 | w_ex2_rs2;
      exec_pkg::OP_XOR: w_ex2_result = w_ex2_rs1 ^ w_ex2_rs2;
      default:          w_ex2_result = '0;
    endcase
  end

  // ex3: result out
  always_ff @(posedge i_clk) begin
    r_ex3_result <= w_ex2_result;
  end

  // illegal ops complete without a target
  assign o_target.valid   = r_ex3_issue.valid & r_ex3_issue.rd_valid & r_ex3_legal;
  assign o_target.rd_type = exec_pkg::GPR;
  assign o_target.rd_rnid = r_ex3_issue.rd_rnid;
  assign o_target.rd_data = r_ex3_result;

  assign o_done       = r_ex3_issue.valid;
  assign o_done_index = r_ex3_issue.index;

endmodule

//--- source/exec_unit_top.sv
`timescale 1ns/1ps
`include "exec_defs.svh"

module exec_unit_top (
  input  logic                        i_clk,
  input  logic                        i_reset_n,
  input  exec_pkg::issue_t            i_issue,
  input  exec_pkg::target_t           i_ext_target,
  output exec_pkg::release_t          o_release,
  output exec_pkg::target_t           o_target,
  output logic                        o_done,
  output logic [`EXEC_RV_ENTRIES-1:0] o_done_index
);

  exec_pkg::inst_u       w_ex0_inst;
  exec_pkg::pipe_ctrl_t  w_ex0_ctrl;
  exec_pkg::regread_t    w_rd_req [2];
  logic [`EXEC_XLEN-1:0] w_rd_data [2];
  exec_pkg::target_t     w_pipe_target;
  exec_pkg::target_t     w_targets [`EXEC_TGT_BUS_SIZE];

  // slot 0 own result, slot 1 external writer
  assign w_targets[0] = w_pipe_target;
  assign w_targets[1] = i_ext_target;
  assign o_target     = w_pipe_target;

  inst_decoder u_decoder (
    .i_inst (w_ex0_inst),
    .o_ctrl (w_ex0_ctrl)
  );

  phys_regfile u_regfile (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_rd_req  (w_rd_req),
    .o_rd_data (w_rd_data),
    .i_targets (w_targets)
  );

  alu_pipe u_pipe (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_issue      (i_issue),
    .o_ex0_inst   (w_ex0_inst),
    .i_ex0_ctrl   (w_ex0_ctrl),
    .o_rd_req     (w_rd_req),
    .i_rd_data    (w_rd_data),
    .i_targets    (w_targets),
    .o_release    (o_release),
    .o_target     (w_pipe_target),
    .o_done       (o_done),
    .o_done_index (o_done_index)
  );

endmodule

//--- verification/tb_exec_unit.sv
`timescale 1ns/1ps
`include "exec_defs.svh"

module tb_exec_unit;

  typedef struct packed {
    logic                        valid;
    logic                        has_target;
    logic [`EXEC_RNID_W-1:0]     rd_rnid;
    logic [`EXEC_RV_ENTRIES-1:0] index;
    logic [`EXEC_XLEN-1:0]       data;
  } exp_t;

  logic                        i_clk;
  logic                        i_reset_n;
  exec_pkg::issue_t            i_issue;
  exec_pkg::target_t           i_ext_target;
  exec_pkg::release_t          o_release;
  exec_pkg::target_t           o_target;
  logic                        o_done;
  logic [`EXEC_RV_ENTRIES-1:0] o_done_index;

  logic [`EXEC_XLEN-1:0]   ref_regs [`EXEC_PHYS_REGS];
  exp_t                    exp_stage [4];
  exec_pkg::target_t       ext_q [2];
  logic [`EXEC_RNID_W-1:0] recent_rd [3];
  logic [`EXEC_RNID_W-1:0] recent_ext;
  logic [31:0]             lcg_state;
  int                      issue_count;
  int                      done_count = 0;

  initial i_clk = 1'b0;
  always #50 i_clk = ~i_clk;

  exec_unit_top i_dut (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_issue      (i_issue),
    .i_ext_target (i_ext_target),
    .o_release    (o_release),
    .o_target     (o_target),
    .o_done       (o_done),
    .o_done_index (o_done_index)
  );

  function automatic logic [15:0] rand16();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    rand16    = lcg_state[31:16];
  endfunction

  // rnids 48 and up are kept for the external writer
  function automatic logic [5:0] pick_rd();
    pick_rd = 6'(rand16() % 16'd48);
  endfunction

  // mostly the rd of one of the last three issues or the last external gpr write
  function automatic logic [5:0] pick_src();
    logic [15:0] r;
    r = rand16();
    case (r[1:0])
      2'd0:    pick_src = recent_rd[0];
      2'd1:    pick_src = recent_rd[1];
      2'd2:    pick_src = recent_rd[2];
      default: pick_src = r[2] ? recent_ext : r[7:2];
    endcase
  endfunction

  // op 1 add, 2 sub, 3 and, 4 or, 5 xor
  function automatic logic [2:0] op_funct3(input int op);
    case (op)
      3:       op_funct3 = 3'b111;
      4:       op_funct3 = 3'b110;
      5:       op_funct3 = 3'b100;
      default: op_funct3 = 3'b000;
    endcase
  endfunction

  function automatic logic [31:0] alu_model(input int op, input logic [31:0] a,
                                            input logic [31:0] b);
    case (op)
      2:       alu_model = a - b;
      3:       alu_model = a & b;
      4:       alu_model = a | b;
      5:       alu_model = a ^ b;
      default: alu_model = a + b;
    endcase
  endfunction

  task automatic report_mismatch(input string msg);
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
    $display("TB FAILED");
    $fatal(1, "stopped at first error");
  endtask

  // ext writes show on the bus two cycles after they are decided
  task automatic drive_cycle(input exec_pkg::issue_t iss, input exp_t e,
                             input exec_pkg::target_t ext);
    i_issue      <= iss;
    i_ext_target <= ext_q[1];
    ext_q[1]     <= ext_q[0];
    ext_q[0]     <= ext;
    exp_stage[0] <= e;
    exp_stage[1] <= exp_stage[0];
    exp_stage[2] <= exp_stage[1];
    exp_stage[3] <= exp_stage[2];
  endtask

  task automatic issue_random();
    exec_pkg::issue_t      iss;
    exec_pkg::target_t     ext;
    exp_t                  e;
    logic [15:0]           r;
    int                    kind;
    logic [`EXEC_XLEN-1:0] a;
    logic [`EXEC_XLEN-1:0] b;
    logic [`EXEC_XLEN-1:0] res;
    iss = '0;
    ext = '0;
    e   = '0;
    res = '0;
    r   = rand16();
    if (r[2:0] == 3'd0) begin
      ext.valid   = 1'b1;
      ext.rd_type = r[3] ? exec_pkg::FPR : exec_pkg::GPR;
      ext.rd_rnid = r[3] ? pick_src() : {2'b11, r[7:4]};
      ext.rd_data = {rand16(), rand16()};
      // fpr writes never reach gpr sources
      if (!r[3]) begin
        ref_regs[ext.rd_rnid] = ext.rd_data;
        recent_ext            = ext.rd_rnid;
      end
    end
    if (r[15:12] != 4'd0) begin
      kind         = int'(rand16() % 16'd12);
      iss.valid    = 1'b1;
      iss.rd_valid = 1'b1;
      iss.rd_type  = exec_pkg::GPR;
      iss.rd_rnid  = pick_rd();
      iss.rs1_type = exec_pkg::GPR;
      iss.rs1_rnid = pick_src();
      iss.rs2_type = exec_pkg::GPR;
      iss.rs2_rnid = pick_src();
      iss.index    = 8'b1 << r[10:8];
      a = ref_regs[iss.rs1_rnid];
      b = ref_regs[iss.rs2_rnid];
      case (kind)
        0: begin
          iss.inst.u_view.opcode = 7'b0110111;
          iss.inst.u_view.imm20  = {r[3:0], rand16()};
          res = 32'(iss.inst.u_view.imm20) << 12;
        end
        1, 2, 3, 4, 5: begin
          iss.rs1_valid = 1'b1;
          iss.rs2_valid = 1'b1;
          iss.inst.r_view.opcode = 7'b0110011;
          iss.inst.r_view.funct7 = (kind == 2) ? 7'b0100000 : 7'b0000000;
          iss.inst.r_view.funct3 = op_funct3(kind);
          res = alu_model(kind, a, b);
        end
        6, 7, 8, 9: begin
          iss.rs1_valid = 1'b1;
          iss.inst.i_view.opcode = 7'b0010011;
          iss.inst.i_view.imm12  = 12'(rand16());
          iss.inst.i_view.funct3 = op_funct3((kind == 6) ? 1 : kind - 4);
          b   = 32'(signed'(iss.inst.i_view.imm12));
          res = alu_model((kind == 6) ? 1 : kind - 4, a, b);
        end
        default: begin
          // load opcode or mul encoding
          iss.rs1_valid = 1'b1;
          iss.rs2_valid = 1'b1;
          iss.inst.r_view.opcode = (kind == 10) ? 7'b0000011 : 7'b0110011;
          iss.inst.r_view.funct7 = 7'b0000001;
        end
      endcase
      e.valid      = 1'b1;
      e.has_target = (kind < 10);
      e.rd_rnid    = iss.rd_rnid;
      e.index      = iss.index;
      e.data       = res;
      if (kind < 10) begin
        ref_regs[iss.rd_rnid] = res;
      end
      issue_count++;
    end
    recent_rd[2] = recent_rd[1];
    recent_rd[1] = recent_rd[0];
    recent_rd[0] = iss.rd_rnid;
    drive_cycle(iss, e, ext);
  endtask

  // outputs only move on the rising edge
  assert property (@(negedge i_clk)
      o_release.valid == (exp_stage[1].valid & exp_stage[1].has_target))
    else report_mismatch($sformatf("release valid is %b", o_release.valid));
  assert property (@(negedge i_clk) !o_release.valid ||
      (o_release.rd_type == exec_pkg::GPR && o_release.rd_rnid == exp_stage[1].rd_rnid))
    else report_mismatch($sformatf("release rnid %0d, expected %0d",
                                   o_release.rd_rnid, exp_stage[1].rd_rnid));
  assert property (@(negedge i_clk) o_done == exp_stage[3].valid)
    else report_mismatch($sformatf("done is %b", o_done));
  assert property (@(negedge i_clk) !o_done || o_done_index == exp_stage[3].index)
    else report_mismatch($sformatf("done index %b, expected %b",
                                   o_done_index, exp_stage[3].index));
  assert property (@(negedge i_clk)
      o_target.valid == (exp_stage[3].valid & exp_stage[3].has_target))
    else report_mismatch($sformatf("target valid is %b", o_target.valid));
  assert property (@(negedge i_clk) !o_target.valid ||
      (o_target.rd_type == exec_pkg::GPR && o_target.rd_rnid == exp_stage[3].rd_rnid &&
       o_target.rd_data == exp_stage[3].data))
    else report_mismatch($sformatf("target type %b p%0d = %h, expected gpr p%0d = %h",
                                   o_target.rd_type, o_target.rd_rnid, o_target.rd_data,
                                   exp_stage[3].rd_rnid, exp_stage[3].data));

  always @(negedge i_clk) begin
    if (o_done) begin
      done_count <= done_count + 1;
    end
  end

  initial begin
    lcg_state    = 32'd47;
    issue_count  = 0;
    i_reset_n    = 1'b0;
    i_issue      = '0;
    i_ext_target = '0;
    ext_q[0]     = '0;
    ext_q[1]     = '0;
    recent_ext   = '0;
    for (int k = 0; k < 4; k++) begin
      exp_stage[k] = '0;
    end
    for (int k = 0; k < 3; k++) begin
      recent_rd[k] = '0;
    end
    for (int k = 0; k < `EXEC_PHYS_REGS; k++) begin
      ref_regs[k] = '0;
    end
    repeat (8) @(posedge i_clk);
    i_reset_n <= 1'b1;
    for (int n = 0; n < 600; n++) begin
      @(posedge i_clk);
      issue_random();
    end
    // drain the pipe
    for (int t = 0; t < 20 && done_count != issue_count; t++) begin
      @(posedge i_clk);
      drive_cycle('0, '0, '0);
    end
    if (done_count != issue_count) begin
      $display("timeout: only %0d of %0d issued instructions reported done",
               done_count, issue_count);
      $display("TB FAILED");
      $fatal(1, "no completion arrived");
    end else begin
      $display("TB PASSED");
      $finish;
    end
  end

endmodule

//--- compile.f
+incdir+source
source/exec_pkg.sv
source/inst_decoder.sv
source/phys_regfile.sv
source/alu_pipe.sv
source/exec_unit_top.sv
verification/tb_exec_unit.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --assert
TOP       = tb_exec_unit
FILELIST  = compile.f

.PHONY: sim clean

# the pass line in the output decides the exit status
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | awk '{ print } /TB PASSED/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir
